/* src/adc_pkg.sv */
// data-path types only; samples arrive as 14-bit pairs every clock and streams have no back-pressure
package adc_pkg;

  // ********************
  // data-path widths

  localparam int NUM_CHANNELS = 2;
  localparam int SAMPLE_W = 14;
  localparam int FMT_W = 16;
  localparam int WORD_W = 2 * FMT_W;

  // consecutive pairs needed to enter or leave pattern lock
  localparam int PN_SYNC_COUNT = 8;

  typedef logic [SAMPLE_W-1:0] sample_t;
  typedef logic [FMT_W-1:0] fmt_sample_t;
  // second sample in the upper half
  typedef logic [WORD_W-1:0] fmt_word_t;
  typedef logic [SAMPLE_W-1:0] pn_state_t;

  // ********************
  // channel streams

  // one channel in one clock, sample0 is the older one
  typedef struct packed {
    sample_t sample0;
    sample_t sample1;
    logic    or_flag;
  } adc_raw_t;

  typedef struct packed {
    logic      valid;
    logic      enable;
    fmt_word_t data;
  } adc_stream_t;

  // per-channel status seen by the common registers
  typedef struct packed {
    logic pn_err;
    logic pn_oos;
    logic over_range;
  } chan_flags_t;

endpackage

/* src/up_pkg.sv */
// register bus types and map; word addresses are 8 bit and only one transaction is in flight
package up_pkg;

  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;
  // cycles the bridge waits for an acknowledge before flagging an error
  localparam int BUS_TIMEOUT = 4;

  typedef logic [ADDR_W-1:0] up_addr_t;
  typedef logic [DATA_W-1:0] up_data_t;

  // ********************
  // external request and response

  typedef struct packed {
    logic     wr;
    up_addr_t addr;
    up_data_t wdata;
  } up_req_t;

  typedef struct packed {
    up_data_t rdata;
    logic     err;
  } up_resp_t;

  // shared strobes from the bridge and the reply of each block
  typedef struct packed {
    logic     wreq;
    logic     rreq;
    up_addr_t addr;
    up_data_t wdata;
  } up_strobe_t;

  typedef struct packed {
    logic     wack;
    logic     rack;
    up_data_t rdata;
  } up_ack_t;

  // ********************
  // register map

  localparam up_data_t CORE_VERSION = 32'h0001_0061;
  localparam up_addr_t REG_VERSION = 8'h00;
  localparam up_addr_t REG_SCRATCH = 8'h02;
  localparam up_addr_t REG_STATUS = 8'h10;

  localparam int STATUS_PN_ERR = 0;
  localparam int STATUS_PN_OOS = 1;
  localparam int STATUS_OVR = 2;
  localparam int STATUS_DOVF = 3;

  localparam up_addr_t CHAN_BASE = 8'h20;
  localparam up_addr_t CHAN_STRIDE = 8'h10;
  localparam up_addr_t CH_CTRL = 8'h00;
  localparam up_addr_t CH_STATUS = 8'h01;

  localparam int CH_STAT_PN_ERR = 0;
  localparam int CH_STAT_PN_OOS = 1;
  localparam int CH_STAT_OVR = 2;

  // channel control word, enable sits in bit 0
  typedef struct packed {
    logic sign_ext;
    logic twos_comp;
    logic fmt_en;
    logic enable;
  } ch_ctrl_t;

endpackage

/* src/up_bus_bridge.sv */
// one outstanding request at a time; unmapped addresses answer err=1, rdata=0 after BUS_TIMEOUT
`timescale 1ns/1ps

module up_bus_bridge (
  input  logic               up_clk,
  input  logic               up_rstn,
  input  logic               req_valid,
  output logic               req_ready,
  input  up_pkg::up_req_t    req,
  output logic               resp_valid,
  input  logic               resp_ready,
  output up_pkg::up_resp_t   resp,
  output up_pkg::up_strobe_t strobe,
  input  up_pkg::up_ack_t    ack_vec [adc_pkg::NUM_CHANNELS+1]
);

  import up_pkg::*;

  localparam int CNT_W = $clog2(BUS_TIMEOUT + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT,
    ST_RESP
  } state_t;

  state_t           state;
  up_req_t          req_q;
  logic             wreq_q;
  logic             rreq_q;
  logic [CNT_W-1:0] wait_cnt;
  logic             accept;
  logic             acked;
  up_ack_t          ack_or;

  // idle blocks return zero, so a plain OR picks the addressed one
  always_comb begin
    ack_or = '0;
    for (int i = 0; i < $size(ack_vec); i++) begin
      ack_or.wack = ack_or.wack | ack_vec[i].wack;
      ack_or.rack = ack_or.rack | ack_vec[i].rack;
      ack_or.rdata = ack_or.rdata | ack_vec[i].rdata;
    end
  end

  assign req_ready = (state == ST_IDLE);
  assign resp_valid = (state == ST_RESP);
  assign accept = req_valid & req_ready;
  assign acked = ack_or.wack | ack_or.rack;
  assign strobe = '{wreq: wreq_q, rreq: rreq_q, addr: req_q.addr, wdata: req_q.wdata};

  // ********************
  // transaction FSM

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      state <= ST_IDLE;
      wreq_q <= 1'b0;
      rreq_q <= 1'b0;
      wait_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state <= ST_ISSUE;
          end
        end
        ST_ISSUE: begin
          wreq_q <= req_q.wr;
          rreq_q <= ~req_q.wr;
          wait_cnt <= '0;
          state <= ST_WAIT;
        end
        ST_WAIT: begin
          wreq_q <= 1'b0;
          rreq_q <= 1'b0;
          if (acked || (wait_cnt == CNT_W'(BUS_TIMEOUT))) begin
            state <= ST_RESP;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        default: begin
          if (resp_ready) begin
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // request and response payload
  always_ff @(posedge up_clk) begin
    if (accept) begin
      req_q <= req;
    end
    if (state == ST_WAIT) begin
      resp.rdata <= ack_or.rdata;
      resp.err <= ~acked;
    end
  end

endmodule

/* src/adc_common_regs.sv */
// only VERSION, SCRATCH and STATUS acknowledge; other addresses in the common range stay silent
`timescale 1ns/1ps

module adc_common_regs (
  input  logic                 up_clk,
  input  logic                 up_rstn,
  input  up_pkg::up_strobe_t   strobe,
  output up_pkg::up_ack_t      ack,
  input  adc_pkg::chan_flags_t chan_flags [adc_pkg::NUM_CHANNELS],
  input  logic                 adc_dovf
);

  import adc_pkg::*;
  import up_pkg::*;

  up_data_t    scratch;
  logic        dovf_sticky;
  chan_flags_t flags_any;
  up_data_t    status_word;
  up_data_t    rd_mux;
  logic        hit;
  logic        status_wr;

  // any channel raises the common flag
  always_comb begin
    flags_any = '0;
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      flags_any.pn_err = flags_any.pn_err | chan_flags[i].pn_err;
      flags_any.pn_oos = flags_any.pn_oos | chan_flags[i].pn_oos;
      flags_any.over_range = flags_any.over_range | chan_flags[i].over_range;
    end
  end

  always_comb begin
    status_word = '0;
    status_word[STATUS_PN_ERR] = flags_any.pn_err;
    status_word[STATUS_PN_OOS] = flags_any.pn_oos;
    status_word[STATUS_OVR] = flags_any.over_range;
    status_word[STATUS_DOVF] = dovf_sticky;
  end

  // ********************
  // address decode

  always_comb begin
    hit = 1'b1;
    rd_mux = '0;
    case (strobe.addr)
      REG_VERSION: rd_mux = CORE_VERSION;
      REG_SCRATCH: rd_mux = scratch;
      REG_STATUS: rd_mux = status_word;
      default: hit = 1'b0;
    endcase
  end

  assign status_wr = strobe.wreq & (strobe.addr == REG_STATUS);

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      ack <= '0;
      scratch <= '0;
      dovf_sticky <= 1'b0;
    end else begin
      ack.wack <= strobe.wreq & hit;
      ack.rack <= strobe.rreq & hit;
      ack.rdata <= (strobe.rreq & hit) ? rd_mux : '0;
      if (strobe.wreq && (strobe.addr == REG_SCRATCH)) begin
        scratch <= strobe.wdata;
      end
      // a new overflow pulse wins over a clear in the same cycle
      if (adc_dovf) begin
        dovf_sticky <= 1'b1;
      end else if (status_wr && strobe.wdata[STATUS_DOVF]) begin
        dovf_sticky <= 1'b0;
      end
    end
  end

endmodule

/* src/adc_pn_mon.sv */
// expects a 14-bit LFSR sequence with two samples per clock; pn_match lags its pair by one cycle
`timescale 1ns/1ps

module adc_pn_mon (
  input  logic              up_clk,
  input  logic              up_rstn,
  input  adc_pkg::adc_raw_t raw,
  output logic              pn_match,
  output logic              pn_oos
);

  import adc_pkg::*;

  localparam int CNT_W = $clog2(PN_SYNC_COUNT);

  pn_state_t        prev_sample;
  logic             match0;
  logic             match1;
  logic             pair_match;
  logic [CNT_W-1:0] sync_cnt;

  // shift left, new lsb is bit 13 xor bit 12
  function automatic pn_state_t pn_step(pn_state_t s);
    return {s[SAMPLE_W-2:0], s[SAMPLE_W-1] ^ s[SAMPLE_W-2]};
  endfunction

  // ********************
  // pair check

  assign match0 = (raw.sample0 == pn_step(prev_sample));
  assign match1 = (raw.sample1 == pn_step(raw.sample0));
  assign pair_match = match0 & match1;

  // newest sample seeds the check of the next pair
  always_ff @(posedge up_clk) begin
    prev_sample <= raw.sample1;
  end

  // ********************
  // lock tracking

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      pn_match <= 1'b0;
      pn_oos <= 1'b1;
      sync_cnt <= '0;
    end else begin
      pn_match <= pair_match;
      // out of sync counts matches, in sync counts mismatches
      if (pair_match == pn_oos) begin
        if (sync_cnt == CNT_W'(PN_SYNC_COUNT - 1)) begin
          pn_oos <= ~pn_oos;
          sync_cnt <= '0;
        end else begin
          sync_cnt <= sync_cnt + 1'b1;
        end
      end else begin
        sync_cnt <= '0;
      end
    end
  end

endmodule

/* src/adc_channel.sv */
// output word lags its raw pair by two clocks; status flags are sticky until a write of 1
`timescale 1ns/1ps

module adc_channel #(
  parameter int CHANNEL_ID = 0
) (
  input  logic                 up_clk,
  input  logic                 up_rstn,
  input  adc_pkg::adc_raw_t    raw,
  output adc_pkg::adc_stream_t stream,
  input  up_pkg::up_strobe_t   strobe,
  output up_pkg::up_ack_t      ack,
  output adc_pkg::chan_flags_t flags
);

  import adc_pkg::*;
  import up_pkg::*;

  localparam up_addr_t ADDR_CTRL = up_addr_t'(CHAN_BASE + CHANNEL_ID * CHAN_STRIDE + CH_CTRL);
  localparam up_addr_t ADDR_STATUS = up_addr_t'(CHAN_BASE + CHANNEL_ID * CHAN_STRIDE + CH_STATUS);

  ch_ctrl_t  ctrl;
  logic      pn_err;
  logic      over_range;
  logic      pn_match;
  logic      pn_oos;
  logic      hit;
  logic      status_wr;
  up_data_t  rd_mux;
  sample_t   sample0_q;
  sample_t   sample1_q;
  fmt_word_t data_q;
  logic      valid_d;
  logic      valid_q;
  logic      enable_q;

  // offset binary to two's complement, then sign or zero extend
  function automatic fmt_sample_t fmt_sample(sample_t s, ch_ctrl_t c);
    sample_t m;
    m = s;
    if (!c.fmt_en) begin
      return {{(FMT_W-SAMPLE_W){1'b0}}, s};
    end
    if (c.twos_comp) begin
      m[SAMPLE_W-1] = ~m[SAMPLE_W-1];
    end
    if (c.sign_ext) begin
      return {{(FMT_W-SAMPLE_W){m[SAMPLE_W-1]}}, m};
    end
    return {{(FMT_W-SAMPLE_W){1'b0}}, m};
  endfunction

  adc_pn_mon i_pn_mon (
    .up_clk   (up_clk),
    .up_rstn  (up_rstn),
    .raw      (raw),
    .pn_match (pn_match),
    .pn_oos   (pn_oos)
  );

  // ********************
  // data path

  always_ff @(posedge up_clk) begin
    sample0_q <= raw.sample0;
    sample1_q <= raw.sample1;
    data_q <= {fmt_sample(sample1_q, ctrl), fmt_sample(sample0_q, ctrl)};
  end

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      valid_d <= 1'b0;
      valid_q <= 1'b0;
      enable_q <= 1'b0;
    end else begin
      valid_d <= 1'b1;
      valid_q <= valid_d;
      enable_q <= ctrl.enable;
    end
  end

  assign stream = '{valid: valid_q, enable: enable_q, data: data_q};
  assign flags = '{pn_err: pn_err, pn_oos: pn_oos, over_range: over_range};

  // ********************
  // registers

  always_comb begin
    hit = 1'b1;
    rd_mux = '0;
    if (strobe.addr == ADDR_CTRL) begin
      rd_mux = up_data_t'(ctrl);
    end else if (strobe.addr == ADDR_STATUS) begin
      rd_mux[CH_STAT_PN_ERR] = pn_err;
      rd_mux[CH_STAT_PN_OOS] = pn_oos;
      rd_mux[CH_STAT_OVR] = over_range;
    end else begin
      hit = 1'b0;
    end
  end

  assign status_wr = strobe.wreq & (strobe.addr == ADDR_STATUS);

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      ack <= '0;
      ctrl <= '0;
      pn_err <= 1'b0;
      over_range <= 1'b0;
    end else begin
      ack.wack <= strobe.wreq & hit;
      ack.rack <= strobe.rreq & hit;
      ack.rdata <= (strobe.rreq & hit) ? rd_mux : '0;
      if (strobe.wreq && (strobe.addr == ADDR_CTRL)) begin
        ctrl <= ch_ctrl_t'(strobe.wdata[$bits(ch_ctrl_t)-1:0]);
      end
      // clear first so that a new event in the same cycle still lands
      if (status_wr && strobe.wdata[CH_STAT_PN_ERR]) begin
        pn_err <= 1'b0;
      end
      if (!pn_match && !pn_oos) begin
        pn_err <= 1'b1;
      end
      if (status_wr && strobe.wdata[CH_STAT_OVR]) begin
        over_range <= 1'b0;
      end
      if (raw.or_flag) begin
        over_range <= 1'b1;
      end
    end
  end

endmodule

/* src/adc_capture_top.sv */
// single clock domain on up_clk; ack slot 0 is the common block, then one slot per channel
`timescale 1ns/1ps

module adc_capture_top (
  input  logic                 up_clk,
  input  logic                 up_rstn,
  input  logic                 req_valid,
  output logic                 req_ready,
  input  up_pkg::up_req_t      req,
  output logic                 resp_valid,
  input  logic                 resp_ready,
  output up_pkg::up_resp_t     resp,
  input  adc_pkg::adc_raw_t    adc_raw [adc_pkg::NUM_CHANNELS],
  output adc_pkg::adc_stream_t adc_stream [adc_pkg::NUM_CHANNELS],
  input  logic                 adc_dovf
);

  import adc_pkg::*;
  import up_pkg::*;

  up_strobe_t  up_strobe;
  up_ack_t     up_ack [NUM_CHANNELS+1];
  chan_flags_t chan_flags [NUM_CHANNELS];

  // register bus bridge
  up_bus_bridge i_up_bus_bridge (
    .up_clk     (up_clk),
    .up_rstn    (up_rstn),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp       (resp),
    .strobe     (up_strobe),
    .ack_vec    (up_ack)
  );

  adc_common_regs i_common_regs (
    .up_clk     (up_clk),
    .up_rstn    (up_rstn),
    .strobe     (up_strobe),
    .ack        (up_ack[0]),
    .chan_flags (chan_flags),
    .adc_dovf   (adc_dovf)
  );

  // ********************
  // capture channels

  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
    adc_channel #(
      .CHANNEL_ID (i)
    ) i_channel (
      .up_clk  (up_clk),
      .up_rstn (up_rstn),
      .raw     (adc_raw[i]),
      .stream  (adc_stream[i]),
      .strobe  (up_strobe),
      .ack     (up_ack[i+1]),
      .flags   (chan_flags[i])
    );
  end

endmodule

/* verif/adc_capture_props.sv */
// bus handshake and stream timing checks; only active when the simulator enables assertions
`timescale 1ns/1ps

module adc_capture_props (
  input logic                              up_clk,
  input logic                              up_rstn,
  input logic                              req_valid,
  input logic                              req_ready,
  input logic                              resp_valid,
  input logic                              resp_ready,
  input up_pkg::up_resp_t                  resp,
  input logic [adc_pkg::NUM_CHANNELS-1:0]  stream_valid
);

  // a request is outstanding from acceptance until its response is taken
  logic pending;

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      pending <= 1'b0;
    end else if (req_valid && req_ready) begin
      pending <= 1'b1;
    end else if (resp_valid && resp_ready) begin
      pending <= 1'b0;
    end
  end

  // stalled response keeps its value
  property resp_held;
    @(posedge up_clk) disable iff (!up_rstn)
      resp_valid && !resp_ready |=> resp_valid && $stable(resp);
  endproperty

  property single_outstanding;
    @(posedge up_clk) disable iff (!up_rstn)
      pending || resp_valid |-> !req_ready;
  endproperty

  // two clocks after reset release every stream is valid
  property stream_always_valid;
    @(posedge up_clk) disable iff (!up_rstn)
      $past(up_rstn) && $past(up_rstn, 2) |-> &stream_valid;
  endproperty

  assert property (resp_held) else $error("response changed while the master stalled");
  assert property (single_outstanding) else $error("req_ready high with a request outstanding");
  assert property (stream_always_valid) else $error("stream valid dropped after reset");

endmodule

bind adc_capture_top adc_capture_props i_top_props (
  .up_clk       (up_clk),
  .up_rstn      (up_rstn),
  .req_valid    (req_valid),
  .req_ready    (req_ready),
  .resp_valid   (resp_valid),
  .resp_ready   (resp_ready),
  .resp         (resp),
  .stream_valid ({adc_stream[1].valid, adc_stream[0].valid})
);

/* verif/adc_capture_tb.sv */
// reads verif/adc_capture_testdata.txt relative to the project root; needs assertions enabled
`timescale 1ns/1ps

module adc_capture_tb;

  import adc_pkg::*;
  import up_pkg::*;

  localparam int RESET_CYCLES = 3;
  localparam int STALL_CYCLES = 3;
  // longest line is an idle wait or a stalled transaction
  localparam int LINE_CYCLES = 2 * BUS_TIMEOUT + 16;
  localparam int XFER_LIMIT = 4 * BUS_TIMEOUT + 8;

  logic        up_clk;
  logic        up_rstn;
  logic        req_valid;
  logic        req_ready;
  up_req_t     req;
  logic        resp_valid;
  logic        resp_ready;
  up_resp_t    resp;
  adc_raw_t    adc_raw [NUM_CHANNELS];
  adc_stream_t adc_stream [NUM_CHANNELS];
  logic        adc_dovf;

  // pattern source state per channel
  logic [NUM_CHANNELS-1:0] pn_run;
  logic [NUM_CHANNELS-1:0] corrupt;
  logic [NUM_CHANNELS-1:0] or_pulse;
  pn_state_t               pn_state [NUM_CHANNELS];
  logic [3:0]              ctrl_shadow [NUM_CHANNELS];
  fmt_word_t               exp_q [$];
  int                      check_count;
  int                      error_count;
  int                      line_total;

  adc_capture_top UUT (
    .up_clk     (up_clk),
    .up_rstn    (up_rstn),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp       (resp),
    .adc_raw    (adc_raw),
    .adc_stream (adc_stream),
    .adc_dovf   (adc_dovf)
  );

  always #10 up_clk = ~up_clk;

  // 14-bit lfsr step with new lsb from bits 13 and 12
  function automatic pn_state_t next_pattern(pn_state_t s);
    return {s[12:0], s[13] ^ s[12]};
  endfunction

  // ********************
  // helpers

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic require_fields(input int got, input int want);
    if (got != want) begin
      abort_run("malformed line in the test data file");
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] want);
    check_count++;
    assert (got === want)
    else begin
      $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, want);
      error_count++;
    end
  endtask

  // every wait goes through here so that all inputs change on the falling edge
  task automatic tick();
    pn_state_t s0;
    pn_state_t s1;
    @(negedge up_clk);
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      if (pn_run[c]) begin
        s0 = next_pattern(pn_state[c]);
        s1 = next_pattern(s0);
        pn_state[c] = s1;
        adc_raw[c].sample0 = s0;
        adc_raw[c].sample1 = corrupt[c] ? (s1 ^ 14'h0001) : s1;
        adc_raw[c].or_flag = or_pulse[c];
        corrupt[c] = 1'b0;
        or_pulse[c] = 1'b0;
      end
    end
  endtask

  task automatic bus_xfer(input logic wr, input up_addr_t addr, input up_data_t wdata,
                          input int stall, output up_resp_t rsp);
    int       cycles;
    up_resp_t held;
    tick();
    req = '{wr: wr, addr: addr, wdata: wdata};
    req_valid = 1'b1;
    resp_ready = (stall == 0);
    cycles = 0;
    while (!req_ready) begin
      tick();
      cycles++;
      if (cycles > XFER_LIMIT) begin
        abort_run("request was never accepted by the DUT");
      end
    end
    tick();
    req_valid = 1'b0;
    cycles = 0;
    while (!resp_valid) begin
      tick();
      cycles++;
      if (cycles > XFER_LIMIT) begin
        abort_run("DUT gave no response to a register request");
      end
    end
    held = resp;
    // the response must stay put while the master stalls
    for (int i = 0; i < stall; i++) begin
      tick();
      check_value("held resp_valid", 32'(resp_valid), 32'd1);
      check_value("req_ready while pending", 32'(req_ready), 32'd0);
      check_value("held rdata", resp.rdata, held.rdata);
      check_value("held err", 32'(resp.err), 32'(held.err));
    end
    resp_ready = 1'b1;
    rsp = held;
  endtask

  task automatic run_sample(input int ch, input sample_t s0, input sample_t s1,
                            input logic orf, input fmt_word_t exp_word);
    fmt_word_t want;
    tick();
    adc_raw[ch] = '{sample0: s0, sample1: s1, or_flag: orf};
    exp_q.push_back(exp_word);
    tick();
    // the pair is held, so the next clock formats the same word
    exp_q.push_back(exp_word);
    tick();
    want = exp_q.pop_front();
    check_value("stream data", adc_stream[ch].data, want);
    check_value("stream valid", 32'(adc_stream[ch].valid), 32'd1);
    check_value("stream enable", 32'(adc_stream[ch].enable), 32'(ctrl_shadow[ch][0]));
    tick();
    want = exp_q.pop_front();
    check_value("stream data", adc_stream[ch].data, want);
  endtask

  // ********************
  // main sequence

  initial begin
    int          fd;
    int          code;
    int          test_no;
    int          errors_before;
    int          ch;
    byte         op;
    logic [1023:0] line_buf;
    logic [31:0] f_a;
    logic [31:0] f_b;
    logic [31:0] f_c;
    logic [31:0] f_d;
    logic [31:0] f_e;
    up_resp_t    rsp;
    up_clk = 1'b0;
    up_rstn = 1'b0;
    req_valid = 1'b0;
    req = '0;
    resp_ready = 1'b1;
    adc_dovf = 1'b0;
    pn_run = '0;
    corrupt = '0;
    or_pulse = '0;
    check_count = 0;
    error_count = 0;
    line_total = 0;
    // idle samples that never form a pattern
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      adc_raw[c] = '{sample0: 14'h0001, sample1: 14'h0001, or_flag: 1'b0};
      pn_state[c] = '0;
      ctrl_shadow[c] = '0;
    end
    void'($urandom(32'h0614_27a0));

    fd = $fopen("verif/adc_capture_testdata.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open verif/adc_capture_testdata.txt");
    end
    while (!$feof(fd)) begin
      code = $fgets(line_buf, fd);
      if (code != 0) begin
        line_total++;
      end
    end
    $fclose(fd);

    errors_before = error_count;
    repeat (RESET_CYCLES) tick();
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      check_value("valid in reset", 32'(adc_stream[c].valid), 32'd0);
      check_value("enable in reset", 32'(adc_stream[c].enable), 32'd0);
    end
    check_value("req_ready in reset", 32'(req_ready), 32'd1);
    check_value("resp_valid in reset", 32'(resp_valid), 32'd0);
    $display("test 0 (reset): %s", (error_count == errors_before) ? "pass" : "fail");
    up_rstn = 1'b1;

    fd = $fopen("verif/adc_capture_testdata.txt", "r");
    test_no = 0;
    while ($fscanf(fd, " %c", op) == 1) begin
      if (op == "#") begin
        code = $fgets(line_buf, fd);
      end else begin
        test_no++;
        errors_before = error_count;
        case (op)
          "R", "W", "H": begin
            code = $fscanf(fd, "%h %h %h %h", f_a, f_b, f_c, f_d);
            require_fields(code, 4);
            bus_xfer(op == "W", up_addr_t'(f_a), f_b, (op == "H") ? STALL_CYCLES : 0, rsp);
            check_value("rdata", rsp.rdata, f_c);
            check_value("err", 32'(rsp.err), f_d);
            for (int c = 0; c < NUM_CHANNELS; c++) begin
              if (op == "W" && up_addr_t'(f_a) == up_addr_t'(CHAN_BASE + c * CHAN_STRIDE)) begin
                ctrl_shadow[c] = f_b[3:0];
              end
            end
          end
          "S": begin
            code = $fscanf(fd, "%d %h %h %h %h", f_a, f_b, f_c, f_d, f_e);
            require_fields(code, 5);
            ch = int'(f_a);
            run_sample(ch, sample_t'(f_b), sample_t'(f_c), f_d[0], f_e);
          end
          "P": begin
            code = $fscanf(fd, "%d", f_a);
            require_fields(code, 1);
            ch = int'(f_a);
            pn_state[ch] = pn_state_t'($urandom) | 14'h0001;
            pn_run[ch] = 1'b1;
          end
          "C": begin
            code = $fscanf(fd, "%d", f_a);
            require_fields(code, 1);
            ch = int'(f_a);
            corrupt[ch] = 1'b1;
          end
          "O": begin
            code = $fscanf(fd, "%d", f_a);
            require_fields(code, 1);
            ch = int'(f_a);
            or_pulse[ch] = 1'b1;
          end
          "N": begin
            code = $fscanf(fd, "%d", f_a);
            require_fields(code, 1);
            repeat (int'(f_a)) tick();
          end
          "D": begin
            tick();
            adc_dovf = 1'b1;
            tick();
            adc_dovf = 1'b0;
          end
          default: begin
            abort_run("unknown operation in the test data file");
          end
        endcase
        $display("test %0d (%c): %s", test_no, op,
                 (error_count == errors_before) ? "pass" : "fail");
      end
    end
    $fclose(fd);

    $display("summary: %0d tests, %0d checks, %0d errors", test_no, check_count, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog sized from the number of data lines
  initial begin
    wait (line_total > 0);
    repeat ((line_total + RESET_CYCLES) * LINE_CYCLES) @(posedge up_clk);
    abort_run("watchdog expired before the test data was finished");
  end

endmodule

/* verif/adc_capture_testdata.txt */
# R/W/H addr wdata exp_rdata exp_err (H stalls the response) ; S ch s0 s1 or exp_word
# P ch starts pattern ; C ch corrupts one sample ; O ch over-range pulse ; N cycles ; D overflow
R 00 0 00010061 0
W 02 a5a55a5a 0 0
R 02 0 a5a55a5a 0
R 7f 0 00000000 1
H 00 0 00010061 0
R 10 0 00000002 0
R 21 0 00000002 0
R 31 0 00000002 0
W 20 1 0 0
R 20 0 00000001 0
S 0 0001 3fff 0 3fff0001
W 20 3 0 0
S 0 2000 1fff 0 1fff2000
W 20 7 0 0
S 0 2000 1fff 0 3fff0000
W 20 f 0 0
S 0 2000 1fff 0 ffff0000
W 20 b 0 0
S 0 2000 1fff 0 1fffe000
S 1 0abc 2def 0 2def0abc
P 0
P 1
N 14
R 21 0 00000000 0
R 31 0 00000000 0
R 10 0 00000000 0
C 0
N 3
R 21 0 00000001 0
R 10 0 00000001 0
W 21 1 0 0
R 21 0 00000000 0
O 1
N 2
R 31 0 00000004 0
R 21 0 00000000 0
R 10 0 00000004 0
D
N 2
R 10 0 0000000c 0
W 10 8 0 0
R 10 0 00000004 0

/* project.f */
src/adc_pkg.sv
src/up_pkg.sv
src/up_bus_bridge.sv
src/adc_common_regs.sv
src/adc_pn_mon.sv
src/adc_channel.sv
src/adc_capture_top.sv
verif/adc_capture_props.sv
verif/adc_capture_tb.sv

/* Makefile */
SIM := obj_dir/Vadc_capture_tb
SRCS := $(shell grep -v '^+' project.f)

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q '^TEST OK$$'

$(SIM): project.f $(SRCS)
	verilator --binary --timing --assert --top-module adc_capture_tb -f project.f

clean:
	rm -rf obj_dir
